/* list.f */
rob_cfg_pkg.sv
rob_types_pkg.sv
rob_ptr.sv
rob_disp_fmt.sv
rob_entry.sv
rob_commit_sel.sv
rob_top.sv
tb_rob.sv

/* rob_cfg_pkg.sv */
package rob_cfg_pkg;

  // ----------------------------------------
  // buffer geometry
  // ----------------------------------------
  localparam int DISP_SIZE      = 4;  // slots per dispatch group
  localparam int CMT_ENTRY_SIZE = 8;  // group entries
  localparam int CMT_ENTRY_W    = $clog2(CMT_ENTRY_SIZE);

  // ----------------------------------------
  // widths with a meaning
  // ----------------------------------------

  // one bit per slot of a group
  typedef logic [DISP_SIZE-1:0] grp_id_t;

  // entry index, msb is the wrap bit
  typedef logic [CMT_ENTRY_W:0] cmt_id_t;

  typedef logic [31:0] pc_t;  // instruction address

  // [2] external, [1] timer, [0] software
  typedef logic [2:0] int_req_t;

endpackage

/* rob_commit_sel.sv */
module rob_commit_sel (
  input  rob_types_pkg::rob_entry_t   i_entries [rob_cfg_pkg::CMT_ENTRY_SIZE],
  input  logic [rob_cfg_pkg::CMT_ENTRY_SIZE-1:0] i_all_done,
  input  rob_cfg_pkg::cmt_id_t        i_out_ptr,
  input  rob_cfg_pkg::int_req_t       i_int_req,
  output rob_types_pkg::commit_blk_t  o_commit,
  output logic                        o_commit_valid,
  output logic                        o_flush,
  output rob_types_pkg::rob_info_t    o_rob_info
);

  import rob_cfg_pkg::*;
  import rob_types_pkg::*;

  localparam int SLOT_W = $clog2(DISP_SIZE);

  rob_entry_t              w_head;
  logic [CMT_ENTRY_W-1:0]  w_head_idx;
  logic                    w_commit;
  grp_id_t                 w_exc_grp;   // excepting valid slots
  logic                    w_exc_any;
  logic [SLOT_W-1:0]       w_exc_idx;   // lowest excepting slot
  grp_id_t                 w_exc_dead;  // slots after it
  except_t                 w_exc_type;
  pc_t                     w_exc_pc;
  logic                    w_int_valid;
  except_t                 w_int_type;

  assign w_head_idx = i_out_ptr[CMT_ENTRY_W-1:0];
  assign w_head     = i_entries[w_head_idx];
  assign w_commit   = i_all_done[w_head_idx];

  // ----------------------------------------
  // exception select
  // ----------------------------------------
  assign w_exc_grp = w_head.except_valid & w_head.grp_id;
  assign w_exc_any = |w_exc_grp;

  // scan downward so the lowest slot is left
  always_comb begin
    w_exc_idx = '0;
    for (int d = DISP_SIZE-1; d >= 0; d--) begin
      if (w_exc_grp[d]) begin
        w_exc_idx = SLOT_W'(d);
      end
    end
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_exc_dead[d] = w_exc_any && (SLOT_W'(d) > w_exc_idx);
    end
  end

  assign w_exc_type = w_exc_any ? w_head.except_type[w_exc_idx] : EXC_NONE;
  assign w_exc_pc   = w_head.pc + (pc_t'(w_exc_idx) << 2);  // 4 bytes per slot

  // ----------------------------------------
  // interrupts, taken only on a commit
  // ----------------------------------------
  assign w_int_valid = w_commit && (|i_int_req);

  always_comb begin
    if (i_int_req[2]) begin
      w_int_type = INT_M_EXT;
    end else if (i_int_req[1]) begin
      w_int_type = INT_M_TIMER;
    end else if (i_int_req[0]) begin
      w_int_type = INT_M_SOFT;
    end else begin
      w_int_type = EXC_NONE;
    end
  end

  // ----------------------------------------
  // commit block
  // ----------------------------------------
  always_comb begin
    o_commit              = '0;
    o_commit.commit       = w_commit;
    o_commit.cmt_id       = i_out_ptr;
    o_commit.grp_id       = w_head.grp_id;
    o_commit.dead_id      = (w_head.dead | w_exc_dead) & w_head.grp_id;
    o_commit.except_valid = w_exc_any || w_int_valid;
    o_commit.int_valid    = w_int_valid;
    o_commit.except_type  = w_int_valid ? w_int_type : w_exc_type;
    o_commit.epc          = w_exc_pc;  // base pc when nothing excepts
    o_commit.flush_valid  = w_commit && (w_exc_any || w_int_valid);
  end

  assign o_commit_valid = w_commit;
  assign o_flush        = o_commit.flush_valid;

  assign o_rob_info.cmt_id       = i_out_ptr;
  assign o_rob_info.grp_id       = w_head.grp_id;
  assign o_rob_info.done_grp_id  = w_head.done_grp_id;
  assign o_rob_info.except_valid = w_head.except_valid;

endmodule

/* rob_disp_fmt.sv */
module rob_disp_fmt (
  input  rob_types_pkg::disp_t      i_disp,
  input  rob_cfg_pkg::cmt_id_t      i_in_ptr,
  input  logic                      i_flush,
  output rob_types_pkg::rob_entry_t o_entry
);

  import rob_cfg_pkg::*;
  import rob_types_pkg::*;

  grp_id_t w_fe_exc;  // front-end faults on valid slots

  assign w_fe_exc = i_disp.fe_except & i_disp.grp_id;

  always_comb begin
    o_entry            = '0;
    o_entry.valid      = 1'b1;
    o_entry.cmt_id_msb = i_in_ptr[CMT_ENTRY_W];
    o_entry.grp_id     = i_disp.grp_id;
    o_entry.pc         = i_disp.pc;

    // faulting slots never reach execution, so done on arrival
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_entry.done_grp_id[d]  = w_fe_exc[d];
      o_entry.except_valid[d] = w_fe_exc[d];
      o_entry.except_type[d]  = w_fe_exc[d] ? i_disp.fe_cause[d] : EXC_NONE;
    end

    // group arriving under a flush is already killed
    if (i_flush) begin
      o_entry.done_grp_id  = i_disp.grp_id;
      o_entry.dead         = i_disp.grp_id;
      o_entry.except_valid = '0;
    end
  end

endmodule

/* rob_entry.sv */
module rob_entry #(
  parameter int DONE_PORTS = 3,
  parameter int ENTRY_IDX  = 0
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  rob_cfg_pkg::cmt_id_t      i_in_ptr,
  input  rob_cfg_pkg::cmt_id_t      i_out_ptr,
  input  logic                      i_load_valid,
  input  rob_types_pkg::rob_entry_t i_entry_in,
  input  rob_types_pkg::done_rpt_t  i_done_rpt [DONE_PORTS],
  input  logic                      i_commit,
  input  logic                      i_kill,
  output rob_types_pkg::rob_entry_t o_entry,
  output logic                      o_all_done
);

  import rob_cfg_pkg::*;
  import rob_types_pkg::*;

  rob_entry_t r_entry;
  rob_entry_t w_next;
  cmt_id_t    w_my_id;  // index plus stored wrap bit
  logic       w_load;
  logic       w_retire;

  assign w_my_id  = {r_entry.cmt_id_msb, CMT_ENTRY_W'(ENTRY_IDX)};
  assign w_load   = i_load_valid && (i_in_ptr[CMT_ENTRY_W-1:0] == CMT_ENTRY_W'(ENTRY_IDX));
  assign w_retire = i_commit && (i_out_ptr[CMT_ENTRY_W-1:0] == CMT_ENTRY_W'(ENTRY_IDX));

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    w_next = r_entry;
    if (w_retire) begin
      w_next.valid       = 1'b0;
      w_next.done_grp_id = '0;
    end else if (w_load) begin
      w_next = i_entry_in;
    end else if (r_entry.valid) begin
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (i_done_rpt[p].valid && (i_done_rpt[p].cmt_id == w_my_id)) begin
          w_next.done_grp_id = w_next.done_grp_id | i_done_rpt[p].grp_id;
          for (int d = 0; d < DISP_SIZE; d++) begin
            if (i_done_rpt[p].grp_id[d] && i_done_rpt[p].except_valid) begin
              w_next.except_valid[d] = 1'b1;
              w_next.except_type[d]  = i_done_rpt[p].except_type;
            end
          end
        end
      end
      // flush from an older group wins over late reports
      if (i_kill) begin
        w_next.done_grp_id  = r_entry.grp_id;
        w_next.dead         = r_entry.grp_id;
        w_next.except_valid = '0;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry <= '0;
    end else begin
      r_entry <= w_next;
    end
  end

  assign o_entry    = r_entry;
  assign o_all_done = r_entry.valid && ((r_entry.grp_id & ~r_entry.done_grp_id) == '0);

  // ----------------------------------------
  // report must address a dispatched slot
  // ----------------------------------------
  for (genvar p = 0; p < DONE_PORTS; p++) begin : g_rpt_chk
    a_rpt_in_grp: assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      (i_done_rpt[p].valid && r_entry.valid && (i_done_rpt[p].cmt_id == w_my_id))
        |-> ((i_done_rpt[p].grp_id & ~r_entry.grp_id) == '0)
    ) else $error("completion report for a slot outside entry %0d", ENTRY_IDX);
  end

endmodule

/* rob_ptr.sv */
module rob_ptr (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_in_valid,   // dispatch
  input  logic                 i_out_valid,  // commit
  output rob_cfg_pkg::cmt_id_t o_in_ptr,
  output rob_cfg_pkg::cmt_id_t o_out_ptr,
  output logic                 o_full
);

  import rob_cfg_pkg::*;

  cmt_id_t r_in_ptr;
  cmt_id_t r_out_ptr;
  logic    w_empty;

  // index bits wrap into the msb
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (i_in_valid) begin
        r_in_ptr <= r_in_ptr + cmt_id_t'(1);
      end
      if (i_out_valid) begin
        r_out_ptr <= r_out_ptr + cmt_id_t'(1);
      end
    end
  end

  // same index, wrap bits tell full from empty
  assign o_full  = (r_in_ptr[CMT_ENTRY_W-1:0] == r_out_ptr[CMT_ENTRY_W-1:0]) &&
                   (r_in_ptr[CMT_ENTRY_W] != r_out_ptr[CMT_ENTRY_W]);
  assign w_empty = (r_in_ptr == r_out_ptr);

  assign o_in_ptr  = r_in_ptr;
  assign o_out_ptr = r_out_ptr;

  // ----------------------------------------
  // protocol checks
  // ----------------------------------------

  // front end has to hold dispatch on the full level
  a_no_disp_full: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_in_valid |-> !o_full
  ) else $error("dispatch while ROB full");

  // head commit only ever comes from a stored group
  a_no_cmt_empty: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_out_valid |-> !w_empty
  ) else $error("commit while ROB empty");

endmodule

/* rob_stim.txt */
# D pc grp fe cause | R port cmt mask exc type | I level | W cycles | T test number
# E grp dead exc type epc | F full | N next cmt id  (all hex except port, cycles, test)
T 1
D 00001000 1 0 0
D 00001010 1 0 0
D 00001020 1 0 0
R 0 2 1 0 0
R 1 1 1 0 0
R 2 0 1 0 0
E 1 0 0 0 00001000
E 1 0 0 0 00001010
E 1 0 0 0 00001020
W 5
T 2
D 00002000 7 2 2
R 0 3 5 0 0
E 7 4 1 2 00002004
W 5
T 3
D 00003000 f 0 0
R 0 4 4 1 3
R 1 4 1 1 4
R 2 4 a 0 0
E f e 1 4 00003000
W 5
T 4
D 00004000 3 0 0
D 00004010 f 0 0
D 00004020 1 0 0
R 0 5 1 1 3
R 1 5 2 0 0
D 00004030 3 0 0
E 3 2 1 3 00004000
E f f 0 0 00004010
E 1 1 0 0 00004020
E 3 3 0 0 00004030
W 8
T 5
I 3
D 00005000 1 0 0
D 00005010 3 0 0
R 0 9 1 0 0
W 1
I 0
E 1 0 1 6 00005000
E 3 3 0 0 00005010
W 5
T 6
D 00006000 1 0 0
D 00006010 1 0 0
D 00006020 1 0 0
D 00006030 1 0 0
D 00006040 1 0 0
D 00006050 1 0 0
D 00006060 1 0 0
D 00006070 1 0 0
F 1
N 3
R 1 b 1 1 3
E 1 0 1 3 00006000
E 1 1 0 0 00006010
E 1 1 0 0 00006020
E 1 1 0 0 00006030
E 1 1 0 0 00006040
E 1 1 0 0 00006050
E 1 1 0 0 00006060
E 1 1 0 0 00006070
W 12
F 0
N 3

/* rob_top.sv */
module rob_top #(
  parameter int DONE_PORTS = 3
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_disp_valid,
  input  rob_types_pkg::disp_t       i_disp,
  input  rob_types_pkg::done_rpt_t   i_done_rpt [DONE_PORTS],
  input  rob_cfg_pkg::int_req_t      i_int_req,
  output rob_types_pkg::commit_blk_t o_commit,
  output rob_types_pkg::rob_info_t   o_rob_info,
  output rob_cfg_pkg::cmt_id_t       o_new_cmt_id,
  output logic                       o_rob_full
);

  import rob_cfg_pkg::*;
  import rob_types_pkg::*;

  cmt_id_t                   w_in_ptr;
  cmt_id_t                   w_out_ptr;
  rob_entry_t                w_entry_in;  // fresh record for the in slot
  rob_entry_t                w_entries [CMT_ENTRY_SIZE];
  logic [CMT_ENTRY_SIZE-1:0] w_all_done;
  logic                      w_commit_valid;
  logic                      w_flush;

  rob_ptr u_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_in_valid  (i_disp_valid),
    .i_out_valid (w_commit_valid),
    .o_in_ptr    (w_in_ptr),
    .o_out_ptr   (w_out_ptr),
    .o_full      (o_rob_full)
  );

  rob_disp_fmt u_disp_fmt (
    .i_disp   (i_disp),
    .i_in_ptr (w_in_ptr),
    .i_flush  (w_flush),
    .o_entry  (w_entry_in)
  );

  // ----------------------------------------
  // entry array
  // ----------------------------------------
  for (genvar c = 0; c < CMT_ENTRY_SIZE; c++) begin : g_entry
    rob_entry #(
      .DONE_PORTS (DONE_PORTS),
      .ENTRY_IDX  (c)
    ) u_entry (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_in_ptr     (w_in_ptr),
      .i_out_ptr    (w_out_ptr),
      .i_load_valid (i_disp_valid),
      .i_entry_in   (w_entry_in),
      .i_done_rpt   (i_done_rpt),
      .i_commit     (w_commit_valid),
      .i_kill       (w_flush),      // flush kills all younger groups
      .o_entry      (w_entries[c]),
      .o_all_done   (w_all_done[c])
    );
  end

  rob_commit_sel u_commit_sel (
    .i_entries      (w_entries),
    .i_all_done     (w_all_done),
    .i_out_ptr      (w_out_ptr),
    .i_int_req      (i_int_req),
    .o_commit       (o_commit),
    .o_commit_valid (w_commit_valid),
    .o_flush        (w_flush),
    .o_rob_info     (o_rob_info)
  );

  assign o_new_cmt_id = w_in_ptr;  // id of the next dispatch

endmodule

/* rob_types_pkg.sv */
package rob_types_pkg;

  import rob_cfg_pkg::*;

  // ----------------------------------------
  // exception and interrupt causes
  // ----------------------------------------
  typedef enum logic [3:0] {
    EXC_NONE,
    INST_ACC_FAULT,
    ILLEGAL_INST,
    LOAD_ACC_FAULT,
    ECALL,
    INT_M_EXT,
    INT_M_TIMER,
    INT_M_SOFT
  } except_t;

  // ----------------------------------------
  // records between blocks
  // ----------------------------------------

  // one dispatch group from the front end
  typedef struct packed {
    pc_t                          pc;         // pc of slot 0
    grp_id_t                      grp_id;     // valid slots
    grp_id_t                      fe_except;  // front-end fault per slot
    except_t [DISP_SIZE-1:0]      fe_cause;
  } disp_t;

  // completion report from an execution unit
  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    grp_id_t grp_id;        // one-hot slot
    logic    except_valid;
    except_t except_type;
  } done_rpt_t;

  // stored state of one group
  typedef struct packed {
    logic                         valid;
    logic                         cmt_id_msb;  // wrap bit at dispatch
    grp_id_t                      grp_id;
    grp_id_t                      done_grp_id;
    grp_id_t                      dead;
    grp_id_t                      except_valid;
    except_t [DISP_SIZE-1:0]      except_type;
    pc_t                          pc;
  } rob_entry_t;

  typedef struct packed {
    logic    commit;
    cmt_id_t cmt_id;
    grp_id_t grp_id;
    grp_id_t dead_id;
    logic    except_valid;
    logic    int_valid;
    except_t except_type;
    pc_t     epc;
    logic    flush_valid;
  } commit_blk_t;

  // head entry snapshot
  typedef struct packed {
    cmt_id_t cmt_id;
    grp_id_t grp_id;
    grp_id_t done_grp_id;
    grp_id_t except_valid;
  } rob_info_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the ROB testbench, exit status follows the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_rob \
  -f list.f -o sim_rob > build.log 2>&1 &&
./obj_dir/sim_rob > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "simulation PASS" || {
  echo "simulation FAIL, see build.log and sim.log"
  exit 1
}

/* tb_rob.sv */
module tb_rob;

  timeunit 1ns;
  timeprecision 100ps;

  import rob_cfg_pkg::*;
  import rob_types_pkg::*;

  localparam int DONE_PORTS = 3;

  typedef struct packed {
    grp_id_t grp;
    grp_id_t dead;
    logic    exc;
    except_t typ;
    pc_t     epc;
  } exp_t;

  logic        i_clk;
  logic        i_reset_n;
  logic        i_disp_valid;
  disp_t       i_disp;
  done_rpt_t   i_done_rpt [DONE_PORTS];
  int_req_t    i_int_req;
  commit_blk_t o_commit;
  rob_info_t   o_rob_info;
  cmt_id_t     o_new_cmt_id;
  logic        o_rob_full;

  string lines[$];
  exp_t  exp_q[$];
  exp_t  mon_exp;
  logic  mon_int;         // expected commit is an interrupt
  int    cmt_count = 0;   // commits seen since reset
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;
  int    limit  = 1000000;

  rob_top #(.DONE_PORTS(DONE_PORTS)) dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;  // 8 ns period
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_grp(input string name, input grp_id_t got, input grp_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_type(input string name, input except_t got, input except_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input cmt_id_t got, input cmt_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------
  // commit monitor sampled mid cycle
  // ----------------------------------------
  always @(negedge i_clk) begin
    if (i_reset_n && o_commit.commit) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("commit at %0t with no expected commit left", $time);
      end else begin
        mon_exp = exp_q.pop_front();
        mon_int = mon_exp.exc && (mon_exp.typ inside {INT_M_EXT, INT_M_TIMER, INT_M_SOFT});
        check_grp("o_commit.grp_id", o_commit.grp_id, mon_exp.grp);
        check_grp("o_commit.dead_id", o_commit.dead_id, mon_exp.dead);
        check_flag("o_commit.except_valid", o_commit.except_valid, mon_exp.exc);
        check_flag("o_commit.int_valid", o_commit.int_valid, mon_int);
        check_flag("o_commit.flush_valid", o_commit.flush_valid, mon_exp.exc);
        check_type("o_commit.except_type", o_commit.except_type, mon_exp.typ);
        check_pc("o_commit.epc", o_commit.epc, mon_exp.epc);
        // groups leave in order, ids wrap modulo 16
        check_id("o_commit.cmt_id", o_commit.cmt_id, cmt_id_t'(cmt_count));
        check_id("o_rob_info.cmt_id", o_rob_info.cmt_id, cmt_id_t'(cmt_count));
        check_grp("o_rob_info.grp_id", o_rob_info.grp_id, mon_exp.grp);
        check_grp("o_rob_info.done_grp_id", o_rob_info.done_grp_id, mon_exp.grp);
        check_flag("o_rob_info.except_valid", |o_rob_info.except_valid,
                   mon_exp.exc && !mon_int);
      end
      cmt_count++;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("run stopped after %0d cycles without finishing the stimulus", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // hold the strobes for one clock and then drop them
  task automatic step_clear();
    @(posedge i_clk);
    #1;
    i_disp_valid = 1'b0;
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_rpt[p] = '0;
    end
  endtask

  task automatic end_test(input int num, input int err_start);
    $display("test %0d finished with %0d errors", num, errors - err_start);
  endtask

  initial begin
    int    fd;
    int    n;
    int    a, b, c, d, e;
    int    cur_test;
    int    err_start;
    string line;
    exp_t  ex;

    i_reset_n    = 1'b0;
    i_disp_valid = 1'b0;
    i_disp       = '0;
    i_int_req    = '0;
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_rpt[p] = '0;
    end
    cur_test  = 0;
    err_start = 0;

    fd = $fopen("rob_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open rob_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    limit = 20 * lines.size() + 100;

    // queue the expected commits before any stimulus
    foreach (lines[i]) begin
      if (lines[i][0] == "E") begin
        n = $sscanf(lines[i], "E %h %h %h %h %h", a, b, c, d, e);
        ex.grp  = grp_id_t'(a);
        ex.dead = grp_id_t'(b);
        ex.exc  = c[0];
        ex.typ  = except_t'(d);
        ex.epc  = pc_t'(e);
        exp_q.push_back(ex);
      end
    end

    repeat (5) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;

    foreach (lines[i]) begin
      case (lines[i][0])
        "T": begin
          if (cur_test > 0) end_test(cur_test, err_start);
          n = $sscanf(lines[i], "T %d", cur_test);
          err_start = errors;
        end
        "D": begin
          n = $sscanf(lines[i], "D %h %h %h %h", b, c, d, e);
          i_disp.pc        = pc_t'(b);
          i_disp.grp_id    = grp_id_t'(c);
          i_disp.fe_except = grp_id_t'(d);
          for (int s = 0; s < DISP_SIZE; s++) begin
            i_disp.fe_cause[s] = except_t'(e);
          end
          i_disp_valid = 1'b1;
          step_clear();
        end
        "R": begin
          n = $sscanf(lines[i], "R %d %h %h %h %h", a, b, c, d, e);
          i_done_rpt[a].valid        = 1'b1;
          i_done_rpt[a].cmt_id       = cmt_id_t'(b);
          i_done_rpt[a].grp_id       = grp_id_t'(c);
          i_done_rpt[a].except_valid = d[0];
          i_done_rpt[a].except_type  = except_t'(e);
          step_clear();
        end
        "I": begin
          n = $sscanf(lines[i], "I %h", b);
          i_int_req = int_req_t'(b);
          step_clear();
        end
        "W": begin
          n = $sscanf(lines[i], "W %d", b);
          repeat (b) @(posedge i_clk);
          #1;
        end
        "F": begin
          n = $sscanf(lines[i], "F %h", b);
          check_flag("o_rob_full", o_rob_full, b[0]);
        end
        "N": begin
          n = $sscanf(lines[i], "N %h", b);
          check_id("o_new_cmt_id", o_new_cmt_id, cmt_id_t'(b));
        end
        default: ;  // E lines already queued
      endcase
    end
    if (cur_test > 0) end_test(cur_test, err_start);

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected commits never happened", exp_q.size());
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
